/* mmio_map_pkg.sv */
// peripheral page address map
package mmio_map_pkg;

  // native bus widths
  localparam int unsigned addr_width = 32;
  localparam int unsigned data_width = 32;
  localparam int unsigned strb_width = data_width / 8;

  // in-page byte offset, the low address bits
  localparam int unsigned off_width = 8;

  // upper address bits that select the page
  localparam logic [addr_width-off_width-1:0] page_base = 24'h030000;

  // gpio registers
  localparam logic [off_width-1:0] off_gpio_dat = 8'h00;
  localparam logic [off_width-1:0] off_gpio_oeb = 8'h04;
  localparam logic [off_width-1:0] off_gpio_pu  = 8'h08;
  localparam logic [off_width-1:0] off_gpio_pd  = 8'h0c;

  // 0x10 and 0x14 stay unmapped

  // read-only straps
  localparam logic [off_width-1:0] off_strap_cfg  = 8'h18;
  localparam logic [off_width-1:0] off_strap_ena  = 8'h1c;
  localparam logic [off_width-1:0] off_strap_pll  = 8'h20;
  localparam logic [off_width-1:0] off_strap_mfgr = 8'h24;
  localparam logic [off_width-1:0] off_strap_prod = 8'h28;
  localparam logic [off_width-1:0] off_strap_rev  = 8'h2c;
  localparam logic [off_width-1:0] off_clk_sel    = 8'h30;

endpackage

/* gpio_pkg.sv */
// gpio and strap definitions
package gpio_pkg;

  // number of gpio pins
  localparam int unsigned gpio_width = 16;

  // drivers off after reset
  localparam logic [gpio_width-1:0] gpio_oeb_reset = '1;

  // pull-up and pull-down bars, active low enables
  localparam logic [gpio_width-1:0] gpio_pu_reset = '0;
  localparam logic [gpio_width-1:0] gpio_pd_reset = '0;

  // strap field widths
  localparam int unsigned strap_cfg_width = 8;
  localparam int unsigned pll_trim_width  = 4;
  localparam int unsigned mfgr_id_width   = 12;
  localparam int unsigned prod_id_width   = 8;
  localparam int unsigned mask_rev_width  = 4;

endpackage

/* mmio_decode.sv */
// peripheral bus request stage
`timescale 1ns/1ps

module mmio_decode (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              mem_valid_i,
  input  logic [mmio_map_pkg::addr_width-1:0] mem_addr_i,
  input  logic [mmio_map_pkg::data_width-1:0] mem_wdata_i,
  input  logic [mmio_map_pkg::strb_width-1:0] mem_wstrb_i,
  input  logic                              done_i,
  output logic                              req_valid_o,
  output logic                              req_hit_o,
  output logic [mmio_map_pkg::off_width-1:0]  req_off_o,
  output logic [mmio_map_pkg::data_width-1:0] req_wdata_o,
  output logic [mmio_map_pkg::strb_width-1:0] req_wstrb_o
);
  import mmio_map_pkg::*;

  logic busy_q;
  logic accept;
  logic page_hit;

  // the master holds valid until ready, so wait for done before taking another
  assign accept = mem_valid_i && !busy_q && !done_i;

  assign page_hit = (mem_addr_i[addr_width-1:off_width] == page_base);

  // control state
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q      <= 1'b0;
      req_valid_o <= 1'b0;
    end else begin
      req_valid_o <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // request payload, captured once per accepted request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_hit_o   <= page_hit;
      req_off_o   <= mem_addr_i[off_width-1:0];
      req_wdata_o <= mem_wdata_i;
      req_wstrb_o <= mem_wstrb_i;
    end
  end

  // no second strobe while the first request is still in flight
  a_no_req_while_busy : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    req_valid_o |=> !req_valid_o ##1 !req_valid_o
  );

  // the response must come back exactly one cycle after the strobe
  a_done_follows_req : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    req_valid_o |=> done_i
  );

endmodule

/* mmio_regfile.sv */
// gpio registers and strap readback
`timescale 1ns/1ps

module mmio_regfile (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   req_valid_i,
  input  logic                                   req_hit_i,
  input  logic [mmio_map_pkg::off_width-1:0]       req_off_i,
  input  logic [mmio_map_pkg::data_width-1:0]      req_wdata_i,
  input  logic [mmio_map_pkg::strb_width-1:0]      req_wstrb_i,
  input  logic [gpio_pkg::gpio_width-1:0]          gpio_in_i,
  input  logic [gpio_pkg::strap_cfg_width-1:0]     strap_cfg_i,
  input  logic                                   xtal_ena_i,
  input  logic                                   reg_ena_i,
  input  logic                                   pll_cp_ena_i,
  input  logic                                   pll_vco_ena_i,
  input  logic                                   pll_bias_ena_i,
  input  logic [gpio_pkg::pll_trim_width-1:0]      pll_trim_i,
  input  logic [gpio_pkg::mfgr_id_width-1:0]       mfgr_id_i,
  input  logic [gpio_pkg::prod_id_width-1:0]       prod_id_i,
  input  logic [gpio_pkg::mask_rev_width-1:0]      mask_rev_i,
  input  logic                                   clk_ext_sel_i,
  output logic [gpio_pkg::gpio_width-1:0]          gpio_out_o,
  output logic [gpio_pkg::gpio_width-1:0]          gpio_outenb_o,
  output logic [gpio_pkg::gpio_width-1:0]          gpio_pullupb_o,
  output logic [gpio_pkg::gpio_width-1:0]          gpio_pulldownb_o,
  output logic                                   done_o,
  output logic [mmio_map_pkg::data_width-1:0]      rdata_o
);
  import mmio_map_pkg::*;
  import gpio_pkg::*;

  logic                  wr_en;
  logic [data_width-1:0] rd_val;

  // byte lanes 0 and 1 cover the sixteen pins, lanes 2 and 3 are dropped
  function automatic logic [gpio_width-1:0] lane_merge(
    input logic [gpio_width-1:0] cur,
    input logic [data_width-1:0] wdata,
    input logic [strb_width-1:0] wstrb
  );
    logic [gpio_width-1:0] res;
    res = cur;
    if (wstrb[0]) begin
      res[7:0] = wdata[7:0];
    end
    if (wstrb[1]) begin
      res[gpio_width-1:8] = wdata[gpio_width-1:8];
    end
    return res;
  endfunction

  // nonzero strobes inside the page mean a write
  assign wr_en = req_valid_i && req_hit_i && (req_wstrb_i != '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_out_o       <= '0;
      gpio_outenb_o    <= gpio_oeb_reset;
      gpio_pullupb_o   <= gpio_pu_reset;
      gpio_pulldownb_o <= gpio_pd_reset;
    end else if (wr_en) begin
      case (req_off_i)
        off_gpio_dat: gpio_out_o       <= lane_merge(gpio_out_o, req_wdata_i, req_wstrb_i);
        off_gpio_oeb: gpio_outenb_o    <= lane_merge(gpio_outenb_o, req_wdata_i, req_wstrb_i);
        off_gpio_pu:  gpio_pullupb_o   <= lane_merge(gpio_pullupb_o, req_wdata_i, req_wstrb_i);
        off_gpio_pd:  gpio_pulldownb_o <= lane_merge(gpio_pulldownb_o, req_wdata_i, req_wstrb_i);
        default: ;
      endcase
    end
  end

  // read mux, everything zero-extended into the bus word
  always_comb begin
    rd_val = '0;
    if (req_hit_i) begin
      case (req_off_i)
        off_gpio_dat: begin
          rd_val[2*gpio_width-1:gpio_width] = gpio_out_o;
          rd_val[gpio_width-1:0]            = gpio_in_i;
        end
        off_gpio_oeb:   rd_val[gpio_width-1:0]      = gpio_outenb_o;
        off_gpio_pu:    rd_val[gpio_width-1:0]      = gpio_pullupb_o;
        off_gpio_pd:    rd_val[gpio_width-1:0]      = gpio_pulldownb_o;
        off_strap_cfg:  rd_val[strap_cfg_width-1:0] = strap_cfg_i;
        off_strap_ena: begin
          rd_val[1] = xtal_ena_i;
          rd_val[0] = reg_ena_i;
        end
        off_strap_pll: begin
          rd_val[pll_trim_width+2:3] = pll_trim_i;
          rd_val[2]                  = pll_cp_ena_i;
          rd_val[1]                  = pll_vco_ena_i;
          rd_val[0]                  = pll_bias_ena_i;
        end
        off_strap_mfgr: rd_val[mfgr_id_width-1:0]   = mfgr_id_i;
        off_strap_prod: rd_val[prod_id_width-1:0]   = prod_id_i;
        off_strap_rev:  rd_val[mask_rev_width-1:0]  = mask_rev_i;
        off_clk_sel:    rd_val[0]                   = clk_ext_sel_i;
        default: ;
      endcase
    end
  end

  // response control
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= req_valid_i;
    end
  end

  // read data, registered together with done
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rdata_o <= rd_val;
    end
  end

  // a response never overlaps a new request strobe
  a_done_after_req : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    done_o |-> !req_valid_i
  );

endmodule

/* mmio_periph_top.sv */
// peripheral page top
`timescale 1ns/1ps

module mmio_periph_top (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   mem_valid_i,
  input  logic [mmio_map_pkg::addr_width-1:0]      mem_addr_i,
  input  logic [mmio_map_pkg::data_width-1:0]      mem_wdata_i,
  input  logic [mmio_map_pkg::strb_width-1:0]      mem_wstrb_i,
  output logic                                   mem_ready_o,
  output logic [mmio_map_pkg::data_width-1:0]      mem_rdata_o,
  input  logic [gpio_pkg::gpio_width-1:0]          gpio_in_i,
  input  logic [gpio_pkg::strap_cfg_width-1:0]     strap_cfg_i,
  input  logic                                   xtal_ena_i,
  input  logic                                   reg_ena_i,
  input  logic                                   pll_cp_ena_i,
  input  logic                                   pll_vco_ena_i,
  input  logic                                   pll_bias_ena_i,
  input  logic [gpio_pkg::pll_trim_width-1:0]      pll_trim_i,
  input  logic [gpio_pkg::mfgr_id_width-1:0]       mfgr_id_i,
  input  logic [gpio_pkg::prod_id_width-1:0]       prod_id_i,
  input  logic [gpio_pkg::mask_rev_width-1:0]      mask_rev_i,
  input  logic                                   clk_ext_sel_i,
  output logic [gpio_pkg::gpio_width-1:0]          gpio_out_o,
  output logic [gpio_pkg::gpio_width-1:0]          gpio_outenb_o,
  output logic [gpio_pkg::gpio_width-1:0]          gpio_pullupb_o,
  output logic [gpio_pkg::gpio_width-1:0]          gpio_pulldownb_o
);
  import mmio_map_pkg::*;

  logic                  req_valid;
  logic                  req_hit;
  logic [off_width-1:0]  req_off;
  logic [data_width-1:0] req_wdata;
  logic [strb_width-1:0] req_wstrb;
  logic                  done;

  // the response pulse doubles as bus ready
  assign mem_ready_o = done;

  mmio_decode u_decode (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_valid_i (mem_valid_i),
    .mem_addr_i  (mem_addr_i),
    .mem_wdata_i (mem_wdata_i),
    .mem_wstrb_i (mem_wstrb_i),
    .done_i      (done),
    .req_valid_o (req_valid),
    .req_hit_o   (req_hit),
    .req_off_o   (req_off),
    .req_wdata_o (req_wdata),
    .req_wstrb_o (req_wstrb)
  );

  mmio_regfile u_regfile (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req_valid_i      (req_valid),
    .req_hit_i        (req_hit),
    .req_off_i        (req_off),
    .req_wdata_i      (req_wdata),
    .req_wstrb_i      (req_wstrb),
    .gpio_in_i        (gpio_in_i),
    .strap_cfg_i      (strap_cfg_i),
    .xtal_ena_i       (xtal_ena_i),
    .reg_ena_i        (reg_ena_i),
    .pll_cp_ena_i     (pll_cp_ena_i),
    .pll_vco_ena_i    (pll_vco_ena_i),
    .pll_bias_ena_i   (pll_bias_ena_i),
    .pll_trim_i       (pll_trim_i),
    .mfgr_id_i        (mfgr_id_i),
    .prod_id_i        (prod_id_i),
    .mask_rev_i       (mask_rev_i),
    .clk_ext_sel_i    (clk_ext_sel_i),
    .gpio_out_o       (gpio_out_o),
    .gpio_outenb_o    (gpio_outenb_o),
    .gpio_pullupb_o   (gpio_pullupb_o),
    .gpio_pulldownb_o (gpio_pulldownb_o),
    .done_o           (done),
    .rdata_o          (mem_rdata_o)
  );

endmodule

/* tb_mmio_periph.sv */
// peripheral page testbench
`timescale 1ns/1ps

module tb_mmio_periph;
  import mmio_map_pkg::*;
  import gpio_pkg::*;

  localparam int unsigned ready_limit = 16;
  localparam logic [off_width-1:0] unmapped_offs [5] = '{8'h10, 8'h14, 8'h34, 8'h80, 8'hfc};

  logic                       clk_i = 1'b0;
  logic                       rst_n_i;
  logic                       mem_valid_i;
  logic [addr_width-1:0]      mem_addr_i;
  logic [data_width-1:0]      mem_wdata_i;
  logic [strb_width-1:0]      mem_wstrb_i;
  logic                       mem_ready_o;
  logic [data_width-1:0]      mem_rdata_o;
  logic [gpio_width-1:0]      gpio_in_i;
  logic [strap_cfg_width-1:0] strap_cfg_i;
  logic                       xtal_ena_i;
  logic                       reg_ena_i;
  logic                       pll_cp_ena_i;
  logic                       pll_vco_ena_i;
  logic                       pll_bias_ena_i;
  logic [pll_trim_width-1:0]  pll_trim_i;
  logic [mfgr_id_width-1:0]   mfgr_id_i;
  logic [prod_id_width-1:0]   prod_id_i;
  logic [mask_rev_width-1:0]  mask_rev_i;
  logic                       clk_ext_sel_i;
  logic [gpio_width-1:0]      gpio_out_o;
  logic [gpio_width-1:0]      gpio_outenb_o;
  logic [gpio_width-1:0]      gpio_pullupb_o;
  logic [gpio_width-1:0]      gpio_pulldownb_o;

  // expected register contents
  logic [gpio_width-1:0] model_out;
  logic [gpio_width-1:0] model_oeb;
  logic [gpio_width-1:0] model_pu;
  logic [gpio_width-1:0] model_pd;
  logic                  chk_rdata;
  logic [data_width-1:0] exp_rdata;
  logic [31:0]           rng;
  int unsigned           error_count;

  always #4 clk_i = ~clk_i;

  mmio_periph_top dut0 (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .mem_valid_i (mem_valid_i), .mem_addr_i (mem_addr_i),
    .mem_wdata_i (mem_wdata_i), .mem_wstrb_i (mem_wstrb_i),
    .mem_ready_o (mem_ready_o), .mem_rdata_o (mem_rdata_o),
    .gpio_in_i (gpio_in_i), .strap_cfg_i (strap_cfg_i),
    .xtal_ena_i (xtal_ena_i), .reg_ena_i (reg_ena_i),
    .pll_cp_ena_i (pll_cp_ena_i), .pll_vco_ena_i (pll_vco_ena_i),
    .pll_bias_ena_i (pll_bias_ena_i), .pll_trim_i (pll_trim_i),
    .mfgr_id_i (mfgr_id_i), .prod_id_i (prod_id_i),
    .mask_rev_i (mask_rev_i), .clk_ext_sel_i (clk_ext_sel_i),
    .gpio_out_o (gpio_out_o), .gpio_outenb_o (gpio_outenb_o),
    .gpio_pullupb_o (gpio_pullupb_o), .gpio_pulldownb_o (gpio_pulldownb_o)
  );

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
    error_count++;
    $display("FAILED at %0.3f ns: %s is 0x%08h, expected 0x%08h", $realtime, sig, got, exp);
    abort_run();
  endtask

  task automatic protocol_error(input string what);
    error_count++;
    $display("error at %0.3f ns: %s", $realtime, what);
    abort_run();
  endtask

  // between transfers the bus is idle and the pins hold the model
  a_ready_idle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !mem_valid_i |-> !mem_ready_o)
    else value_mismatch("mem_ready_o", $sampled(mem_ready_o), 32'h0);
  a_out : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !mem_valid_i |-> gpio_out_o == model_out)
    else value_mismatch("gpio_out_o", $sampled(gpio_out_o), $sampled(model_out));
  a_oeb : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !mem_valid_i |-> gpio_outenb_o == model_oeb)
    else value_mismatch("gpio_outenb_o", $sampled(gpio_outenb_o), $sampled(model_oeb));
  a_pu : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !mem_valid_i |-> gpio_pullupb_o == model_pu)
    else value_mismatch("gpio_pullupb_o", $sampled(gpio_pullupb_o), $sampled(model_pu));
  a_pd : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !mem_valid_i |-> gpio_pulldownb_o == model_pd)
    else value_mismatch("gpio_pulldownb_o", $sampled(gpio_pulldownb_o), $sampled(model_pd));

  a_rdata : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_ready_o && chk_rdata) |-> mem_rdata_o == exp_rdata)
    else value_mismatch("mem_rdata_o", $sampled(mem_rdata_o), $sampled(exp_rdata));

  // fixed two-edge latency, one-cycle ready
  a_ready_pulse : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(mem_valid_i) |-> !mem_ready_o ##1 !mem_ready_o ##1 mem_ready_o ##1 !mem_ready_o)
    else protocol_error("mem_ready_o did not pulse for one cycle two edges after mem_valid_i");

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // only lanes 0 and 1 reach the pins
  function automatic logic [15:0] apply_strobes(input logic [15:0] cur, input logic [31:0] wdata,
                                                input logic [3:0] wstrb);
    logic [15:0] mask;
    mask = {{8{wstrb[1]}}, {8{wstrb[0]}}};
    return (cur & ~mask) | (wdata[15:0] & mask);
  endfunction

  function automatic logic [31:0] gpio_read_value(input logic [7:0] off, input logic [15:0] pins);
    case (off)
      off_gpio_dat: return {model_out, pins};
      off_gpio_oeb: return {16'h0, model_oeb};
      off_gpio_pu:  return {16'h0, model_pu};
      off_gpio_pd:  return {16'h0, model_pd};
      default:      return 32'h0;
    endcase
  endfunction

  // one transfer, called at a rising edge, returns one idle edge after ready
  task automatic bus_access(input logic [31:0] addr, input logic [3:0] wstrb,
                            input logic [31:0] wdata);
    int unsigned waited;
    waited = 0;
    mem_valid_i <= 1'b1;
    mem_addr_i  <= addr;
    mem_wstrb_i <= wstrb;
    mem_wdata_i <= wdata;
    @(posedge clk_i);
    while (!mem_ready_o && waited < ready_limit) begin
      waited++;
      @(posedge clk_i);
    end
    if (!mem_ready_o) begin
      protocol_error($sformatf("no mem_ready_o came for address 0x%08h", addr));
    end else begin
      mem_valid_i <= 1'b0;
      @(posedge clk_i);
    end
  endtask

  task automatic write_reg(input logic [7:0] off, input logic [3:0] wstrb,
                           input logic [31:0] wdata);
    case (off)
      off_gpio_dat: model_out = apply_strobes(model_out, wdata, wstrb);
      off_gpio_oeb: model_oeb = apply_strobes(model_oeb, wdata, wstrb);
      off_gpio_pu:  model_pu  = apply_strobes(model_pu, wdata, wstrb);
      off_gpio_pd:  model_pd  = apply_strobes(model_pd, wdata, wstrb);
      default: ;
    endcase
    chk_rdata = 1'b0;
    bus_access({page_base, off}, wstrb, wdata);
  endtask

  // a write that must leave every register alone
  task automatic poke_unmapped(input logic [31:0] addr, input logic [31:0] wdata);
    chk_rdata = 1'b0;
    bus_access(addr, 4'hf, wdata);
  endtask

  task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp);
    chk_rdata = 1'b1;
    exp_rdata = exp;
    bus_access(addr, 4'h0, 32'h0);
  endtask

  task automatic drive_straps(input logic [31:0] a, input logic [31:0] b);
    strap_cfg_i    <= a[7:0];
    pll_trim_i     <= a[11:8];
    mfgr_id_i      <= a[23:12];
    prod_id_i      <= a[31:24];
    mask_rev_i     <= b[3:0];
    xtal_ena_i     <= b[4];
    reg_ena_i      <= b[5];
    pll_cp_ena_i   <= b[6];
    pll_vco_ena_i  <= b[7];
    pll_bias_ena_i <= b[8];
    clk_ext_sel_i  <= b[9];
  endtask

  initial begin
    logic [7:0]  off;
    logic [3:0]  strb;
    logic [15:0] pins;
    logic [23:0] upper;
    logic [31:0] sa;
    logic [31:0] sb;
    error_count = 0;
    rng         = 32'haaa0da9d;
    // values after reset
    model_out   = '0;
    model_oeb   = '1;
    model_pu    = '0;
    model_pd    = '0;
    chk_rdata   = 1'b0;
    exp_rdata   = '0;
    rst_n_i     <= 1'b0;
    mem_valid_i <= 1'b0;
    mem_addr_i  <= '0;
    mem_wdata_i <= '0;
    mem_wstrb_i <= '0;
    gpio_in_i   <= '0;
    drive_straps(32'h0, 32'h0);
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge clk_i);

    // random writes to the gpio registers, each read back
    for (int i = 0; i < 48; i++) begin
      rng  = lcg_step(rng);
      off  = {4'h0, rng[31:30], 2'b00};
      strb = rng[27:24];
      if (strb == 4'h0) begin
        strb = 4'hc;
      end
      rng = lcg_step(rng);
      write_reg(off, strb, rng);
      rng  = lcg_step(rng);
      pins = rng[31:16];
      gpio_in_i <= pins;
      read_expect({page_base, off}, gpio_read_value(off, pins));
    end

    // pin inputs under the driven outputs
    for (int i = 0; i < 8; i++) begin
      rng  = lcg_step(rng);
      pins = rng[31:16];
      gpio_in_i <= pins;
      read_expect({page_base, off_gpio_dat}, {model_out, pins});
    end

    // strap packing
    for (int i = 0; i < 4; i++) begin
      rng = lcg_step(rng);
      sa  = rng;
      rng = lcg_step(rng);
      sb  = rng >> 16;
      drive_straps(sa, sb);
      read_expect({page_base, off_strap_cfg}, {24'h0, sa[7:0]});
      read_expect({page_base, off_strap_ena}, {30'h0, sb[4], sb[5]});
      read_expect({page_base, off_strap_pll}, {25'h0, sa[11:8], sb[6], sb[7], sb[8]});
      read_expect({page_base, off_strap_mfgr}, {20'h0, sa[23:12]});
      read_expect({page_base, off_strap_prod}, {24'h0, sa[31:24]});
      read_expect({page_base, off_strap_rev}, {28'h0, sb[3:0]});
      read_expect({page_base, off_clk_sel}, {31'h0, sb[9]});
    end

    // gpio offsets in a foreign page
    for (int i = 0; i < 8; i++) begin
      rng   = lcg_step(rng);
      upper = rng[31:8];
      if (upper == page_base) begin
        upper = ~upper;
      end
      off = {4'h0, rng[31:30], 2'b00};
      poke_unmapped({upper, off}, ~rng);
      read_expect({upper, off}, 32'h0);
    end
    read_expect({page_base + 24'h1, off_gpio_dat}, 32'h0);

    // holes in the page, and a read-only strap
    foreach (unmapped_offs[k]) begin
      rng = lcg_step(rng);
      poke_unmapped({page_base, unmapped_offs[k]}, rng);
      read_expect({page_base, unmapped_offs[k]}, 32'h0);
    end
    poke_unmapped({page_base, off_strap_cfg}, 32'hffff_ffff);

    // one more edge so the idle pin checks see the last write
    @(posedge clk_i);

    if (error_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

/* verilog.f */
mmio_map_pkg.sv
gpio_pkg.sv
mmio_decode.sv
mmio_regfile.sv
mmio_periph_top.sv
tb_mmio_periph.sv

/* Bender.yml */
package:
  name: mmio_periph

sources:
  - files:
      - mmio_map_pkg.sv
      - gpio_pkg.sv
      - mmio_decode.sv
      - mmio_regfile.sv
      - mmio_periph_top.sv
  - target: test
    files:
      - tb_mmio_periph.sv
